//--- csr_unit.f
+incdir+include
src/csr_arch_pkg.sv
src/csr_bus_pkg.sv
src/csr_access.sv
src/irq_ctrl.sv
src/trap_ctrl.sv
src/csr_write_arbiter.sv
src/csr_bank.sv
src/csr_unit.sv
verif/csr_unit_tb.sv

//--- include/csr_macros.svh
`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

// Datapath widths
`define XLEN 32
`define CSR_ADDR_W 12

// mstatus field positions
`define MSTATUS_SIE 1
`define MSTATUS_MIE 3
`define MSTATUS_SPIE 5
`define MSTATUS_MPIE 7
`define MSTATUS_SPP 8
`define MSTATUS_MPP_LO 11

// Vectored mode select in mtvec/stvec
`define TVEC_MODE_BIT 0

// Interrupt bit groups in mip/mie
`define SMASK_INT 32'h0000_0222
`define MMASK_INT 32'h0000_0888

// RV32 with I, S and U
`define MISA_RESET 32'h4014_0100

`endif

//--- src/csr_access.sv
module csr_access (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    req_valid,
  input  csr_bus_pkg::csr_req_t   req,
  output logic                    req_ready,
  input  logic                    grant_instr,
  input  csr_arch_pkg::csr_word_t bank_rdata,
  input  csr_arch_pkg::priv_t     priv,
  output csr_arch_pkg::csr_addr_t rd_addr,
  output csr_bus_pkg::bank_wr_t   wr_req,
  output logic                    rsp_valid,
  output csr_bus_pkg::csr_rsp_t   rsp
);

  import csr_arch_pkg::*;
  import csr_bus_pkg::*;

  logic      known;
  logic      illegal;
  logic      xfer;
  csr_word_t new_val;

  always_comb begin
    case (req.addr)
      CSR_SSTATUS, CSR_SIE, CSR_STVEC, CSR_SSCRATCH,
      CSR_SEPC, CSR_SCAUSE, CSR_STVAL, CSR_SIP,
      CSR_MSTATUS, CSR_MISA, CSR_MEDELEG, CSR_MIE, CSR_MTVEC,
      CSR_MSCRATCH, CSR_MEPC, CSR_MCAUSE, CSR_MTVAL, CSR_MIP: known = 1'b1;
      default: known = 1'b0;
    endcase
  end

  // Bits 9:8 of the address give the lowest privilege allowed
  assign illegal = !known || (req.addr[9:8] > priv);

  always_comb begin
    case (req.op)
      CSR_RW:  new_val = req.wdata;
      CSR_RS:  new_val = bank_rdata | req.wdata;
      CSR_RC:  new_val = bank_rdata & ~req.wdata;
      default: new_val = bank_rdata;
    endcase
  end

  assign req_ready = grant_instr;
  assign xfer      = req_valid && req_ready;
  assign rd_addr   = req.addr;

  // The arbiter decides whether this reaches the bank
  always_comb begin
    wr_req        = '0;
    wr_req.addr   = req.addr;
    wr_req.data   = new_val;
    wr_req.target = priv;
    if (req_valid && !illegal && (req.addr != CSR_MISA)) begin
      wr_req.kind = WR_CSR_WRITE;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= xfer;
    end
  end

  // Old value, captured in the transfer cycle
  always_ff @(posedge clk) begin
    if (xfer) begin
      rsp.rdata   <= illegal ? '0 : bank_rdata;
      rsp.illegal <= illegal;
    end
  end

  // A stalled request stays valid with the same payload
  a_stall_holds: assert property (@(posedge clk) disable iff (!rst_n)
    req_valid && !req_ready |=> req_valid && $stable(req));

endmodule

//--- src/csr_arch_pkg.sv
`include "csr_macros.svh"

package csr_arch_pkg;

  typedef logic [`XLEN-1:0] csr_word_t;

  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_S = 2'd1,
    PRIV_M = 2'd3
  } priv_t;

  // Implemented CSR addresses
  typedef enum logic [`CSR_ADDR_W-1:0] {
    CSR_SSTATUS  = 12'h100,
    CSR_SIE      = 12'h104,
    CSR_STVEC    = 12'h105,
    CSR_SSCRATCH = 12'h140,
    CSR_SEPC     = 12'h141,
    CSR_SCAUSE   = 12'h142,
    CSR_STVAL    = 12'h143,
    CSR_SIP      = 12'h144,
    CSR_MSTATUS  = 12'h300,
    CSR_MISA     = 12'h301,
    CSR_MEDELEG  = 12'h302,
    CSR_MIE      = 12'h304,
    CSR_MTVEC    = 12'h305,
    CSR_MSCRATCH = 12'h340,
    CSR_MEPC     = 12'h341,
    CSR_MCAUSE   = 12'h342,
    CSR_MTVAL    = 12'h343,
    CSR_MIP      = 12'h344
  } csr_addr_t;

  typedef enum logic [3:0] {
    EXC_INSTR_MISALIGN = 4'd0,
    EXC_ILLEGAL_INSTR  = 4'd2,
    EXC_BREAKPOINT     = 4'd3,
    EXC_LOAD_MISALIGN  = 4'd4,
    EXC_LOAD_FAULT     = 4'd5,
    EXC_STORE_MISALIGN = 4'd6,
    EXC_STORE_FAULT    = 4'd7,
    EXC_ECALL_U        = 4'd8,
    EXC_ECALL_S        = 4'd9,
    EXC_ECALL_M        = 4'd11
  } exc_cause_t;

  typedef enum logic [3:0] {
    IRQ_SSI = 4'd1,
    IRQ_MSI = 4'd3,
    IRQ_STI = 4'd5,
    IRQ_MTI = 4'd7,
    IRQ_SEI = 4'd9,
    IRQ_MEI = 4'd11
  } irq_cause_t;

endpackage

//--- src/csr_bank.sv
`include "csr_macros.svh"

module csr_bank (
  input  logic                    clk,
  input  logic                    rst_n,
  input  csr_bus_pkg::bank_wr_t   bank_wr,
  input  csr_arch_pkg::csr_addr_t rd_addr,
  output csr_arch_pkg::csr_word_t rdata,
  output csr_arch_pkg::priv_t     priv,
  output csr_arch_pkg::csr_word_t mstatus,
  output csr_arch_pkg::csr_word_t medeleg,
  output csr_arch_pkg::csr_word_t mie,
  output csr_arch_pkg::csr_word_t mip,
  output csr_arch_pkg::csr_word_t mtvec,
  output csr_arch_pkg::csr_word_t stvec,
  output csr_arch_pkg::csr_word_t mepc,
  output csr_arch_pkg::csr_word_t sepc
);

  import csr_arch_pkg::*;
  import csr_bus_pkg::*;

  localparam csr_word_t SSTATUS_MASK = (csr_word_t'(1) << `MSTATUS_SIE)
                                     | (csr_word_t'(1) << `MSTATUS_SPIE)
                                     | (csr_word_t'(1) << `MSTATUS_SPP);

  csr_word_t mscratch;
  csr_word_t mcause;
  csr_word_t mtval;
  csr_word_t sscratch;
  csr_word_t scause;
  csr_word_t stval;
  csr_word_t mstatus_nx;
  priv_t     priv_nx;
  logic      s_level;

  assign s_level = (bank_wr.addr == CSR_SEPC);

  always_comb begin
    mstatus_nx = mstatus;
    priv_nx    = priv;
    case (bank_wr.kind)
      WR_ENTER: begin
        priv_nx = bank_wr.target;
        if (s_level) begin
          mstatus_nx[`MSTATUS_SPP]  = priv[0];
          mstatus_nx[`MSTATUS_SPIE] = mstatus[`MSTATUS_SIE];
          mstatus_nx[`MSTATUS_SIE]  = 1'b0;
        end else begin
          mstatus_nx[`MSTATUS_MPP_LO +: 2] = priv;
          mstatus_nx[`MSTATUS_MPIE]        = mstatus[`MSTATUS_MIE];
          mstatus_nx[`MSTATUS_MIE]         = 1'b0;
        end
      end
      WR_RETURN: begin
        // Target privilege was taken from SPP/MPP by the trap path
        priv_nx = bank_wr.target;
        if (s_level) begin
          mstatus_nx[`MSTATUS_SIE]  = mstatus[`MSTATUS_SPIE];
          mstatus_nx[`MSTATUS_SPIE] = 1'b1;
          mstatus_nx[`MSTATUS_SPP]  = 1'b0;
        end else begin
          mstatus_nx[`MSTATUS_MIE]         = mstatus[`MSTATUS_MPIE];
          mstatus_nx[`MSTATUS_MPIE]        = 1'b1;
          mstatus_nx[`MSTATUS_MPP_LO +: 2] = PRIV_U;
        end
      end
      WR_CSR_WRITE: begin
        if (bank_wr.addr == CSR_MSTATUS) begin
          mstatus_nx = bank_wr.data;
          // MPP value 2 is reserved, map it to U
          if (bank_wr.data[`MSTATUS_MPP_LO +: 2] == 2'b10) begin
            mstatus_nx[`MSTATUS_MPP_LO +: 2] = PRIV_U;
          end
        end else if (bank_wr.addr == CSR_SSTATUS) begin
          mstatus_nx = (mstatus & ~SSTATUS_MASK) | (bank_wr.data & SSTATUS_MASK);
        end
      end
      default: mstatus_nx = mstatus;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mstatus <= '0;
      priv    <= PRIV_M;
    end else begin
      mstatus <= mstatus_nx;
      priv    <= priv_nx;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      medeleg  <= '0;
      mie      <= '0;
      mip      <= '0;
      mtvec    <= '0;
      mscratch <= '0;
      mepc     <= '0;
      mcause   <= '0;
      mtval    <= '0;
      stvec    <= '0;
      sscratch <= '0;
      sepc     <= '0;
      scause   <= '0;
      stval    <= '0;
    end else if (bank_wr.kind == WR_ENTER) begin
      if (s_level) begin
        sepc   <= bank_wr.epc;
        scause <= bank_wr.cause;
        stval  <= bank_wr.tval;
      end else begin
        mepc   <= bank_wr.epc;
        mcause <= bank_wr.cause;
        mtval  <= bank_wr.tval;
      end
    end else if (bank_wr.kind == WR_CSR_WRITE) begin
      case (bank_wr.addr)
        CSR_MEDELEG:  medeleg  <= bank_wr.data;
        CSR_MIE:      mie      <= bank_wr.data;
        CSR_MIP:      mip      <= bank_wr.data;
        CSR_MTVEC:    mtvec    <= bank_wr.data;
        CSR_MSCRATCH: mscratch <= bank_wr.data;
        CSR_MEPC:     mepc     <= bank_wr.data;
        CSR_MCAUSE:   mcause   <= bank_wr.data;
        CSR_MTVAL:    mtval    <= bank_wr.data;
        CSR_STVEC:    stvec    <= bank_wr.data;
        CSR_SSCRATCH: sscratch <= bank_wr.data;
        CSR_SEPC:     sepc     <= bank_wr.data;
        CSR_SCAUSE:   scause   <= bank_wr.data;
        CSR_STVAL:    stval    <= bank_wr.data;
        // Supervisor views only reach bits 1, 5 and 9
        CSR_SIE: mie <= (mie & ~`SMASK_INT) | (bank_wr.data & `SMASK_INT);
        CSR_SIP: mip <= (mip & ~`SMASK_INT) | (bank_wr.data & `SMASK_INT);
        default: mscratch <= mscratch;
      endcase
    end
  end

  always_comb begin
    case (rd_addr)
      CSR_SSTATUS:  rdata = mstatus & SSTATUS_MASK;
      CSR_SIE:      rdata = mie & `SMASK_INT;
      CSR_STVEC:    rdata = stvec;
      CSR_SSCRATCH: rdata = sscratch;
      CSR_SEPC:     rdata = sepc;
      CSR_SCAUSE:   rdata = scause;
      CSR_STVAL:    rdata = stval;
      CSR_SIP:      rdata = mip & `SMASK_INT;
      CSR_MSTATUS:  rdata = mstatus;
      CSR_MISA:     rdata = `MISA_RESET;
      CSR_MEDELEG:  rdata = medeleg;
      CSR_MIE:      rdata = mie;
      CSR_MTVEC:    rdata = mtvec;
      CSR_MSCRATCH: rdata = mscratch;
      CSR_MEPC:     rdata = mepc;
      CSR_MCAUSE:   rdata = mcause;
      CSR_MTVAL:    rdata = mtval;
      CSR_MIP:      rdata = mip;
      default:      rdata = '0;
    endcase
  end

endmodule

//--- src/csr_bus_pkg.sv
package csr_bus_pkg;

  import csr_arch_pkg::*;

  typedef enum logic [1:0] {
    CSR_RW = 2'd0,
    CSR_RS = 2'd1,
    CSR_RC = 2'd2
  } csr_op_t;

  typedef struct packed {
    csr_op_t   op;
    csr_addr_t addr;
    csr_word_t wdata;
  } csr_req_t;

  typedef struct packed {
    csr_word_t rdata;
    logic      illegal;
  } csr_rsp_t;

  typedef enum logic [1:0] {
    TRAP_NONE = 2'd0,
    TRAP_EXC  = 2'd1,
    TRAP_MRET = 2'd2,
    TRAP_SRET = 2'd3
  } trap_kind_t;

  // pc is the address of the trapping instruction
  typedef struct packed {
    trap_kind_t kind;
    exc_cause_t cause;
    csr_word_t  pc;
    csr_word_t  tval;
  } trap_evt_t;

  typedef enum logic [1:0] {
    WR_IDLE      = 2'd0,
    WR_CSR_WRITE = 2'd1,
    WR_ENTER     = 2'd2,
    WR_RETURN    = 2'd3
  } wr_kind_t;

  // On ENTER/RETURN, addr names the epc of the level involved
  typedef struct packed {
    wr_kind_t  kind;
    csr_addr_t addr;
    csr_word_t data;
    csr_word_t cause;
    csr_word_t epc;
    csr_word_t tval;
    priv_t     target;
  } bank_wr_t;

endpackage

//--- src/csr_unit.sv
module csr_unit (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    req_valid,
  output logic                    req_ready,
  input  csr_bus_pkg::csr_req_t   req,
  output logic                    rsp_valid,
  output csr_bus_pkg::csr_rsp_t   rsp,
  input  csr_bus_pkg::trap_evt_t  evt,
  output logic                    redirect_valid,
  output csr_arch_pkg::csr_word_t redirect_pc,
  output csr_arch_pkg::priv_t     priv,
  output logic                    machine_interrupt
);

  import csr_arch_pkg::*;
  import csr_bus_pkg::*;

  bank_wr_t   instr_req;
  bank_wr_t   trap_req;
  bank_wr_t   bank_wr;
  logic       grant_instr;
  csr_addr_t  rd_addr;
  csr_word_t  rdata;
  csr_word_t  mstatus;
  csr_word_t  medeleg;
  csr_word_t  mie;
  csr_word_t  mip;
  csr_word_t  mtvec;
  csr_word_t  stvec;
  csr_word_t  mepc;
  csr_word_t  sepc;
  irq_cause_t irq_cause;

  csr_access u_access (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid   (req_valid),
    .req         (req),
    .req_ready   (req_ready),
    .grant_instr (grant_instr),
    .bank_rdata  (rdata),
    .priv        (priv),
    .rd_addr     (rd_addr),
    .wr_req      (instr_req),
    .rsp_valid   (rsp_valid),
    .rsp         (rsp)
  );

  irq_ctrl u_irq (
    .mip       (mip),
    .mie       (mie),
    .mstatus   (mstatus),
    .priv      (priv),
    .irq_take  (machine_interrupt),
    .irq_cause (irq_cause)
  );

  trap_ctrl u_trap (
    .clk            (clk),
    .rst_n          (rst_n),
    .evt            (evt),
    .irq_take       (machine_interrupt),
    .irq_cause      (irq_cause),
    .priv           (priv),
    .mstatus        (mstatus),
    .medeleg        (medeleg),
    .mtvec          (mtvec),
    .stvec          (stvec),
    .mepc           (mepc),
    .sepc           (sepc),
    .trap_req       (trap_req),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc)
  );

  csr_write_arbiter u_arb (
    .trap_req    (trap_req),
    .instr_req   (instr_req),
    .grant_instr (grant_instr),
    .bank_wr     (bank_wr)
  );

  csr_bank u_bank (
    .clk     (clk),
    .rst_n   (rst_n),
    .bank_wr (bank_wr),
    .rd_addr (rd_addr),
    .rdata   (rdata),
    .priv    (priv),
    .mstatus (mstatus),
    .medeleg (medeleg),
    .mie     (mie),
    .mip     (mip),
    .mtvec   (mtvec),
    .stvec   (stvec),
    .mepc    (mepc),
    .sepc    (sepc)
  );

endmodule

//--- src/csr_write_arbiter.sv
module csr_write_arbiter (
  input  csr_bus_pkg::bank_wr_t trap_req,
  input  csr_bus_pkg::bank_wr_t instr_req,
  output logic                  grant_instr,
  output csr_bus_pkg::bank_wr_t bank_wr
);

  import csr_bus_pkg::*;

  // Traps cannot be stalled, so they always win
  assign grant_instr = (trap_req.kind == WR_IDLE);
  assign bank_wr     = grant_instr ? instr_req : trap_req;

  always_comb begin
    if (trap_req.kind != WR_IDLE) begin
      a_trap_wins: assert final (bank_wr.kind != WR_CSR_WRITE);
    end
  end

endmodule

//--- src/irq_ctrl.sv
`include "csr_macros.svh"

module irq_ctrl (
  input  csr_arch_pkg::csr_word_t  mip,
  input  csr_arch_pkg::csr_word_t  mie,
  input  csr_arch_pkg::csr_word_t  mstatus,
  input  csr_arch_pkg::priv_t      priv,
  output logic                     irq_take,
  output csr_arch_pkg::irq_cause_t irq_cause
);

  import csr_arch_pkg::*;

  csr_word_t pend;

  // Only the six standard interrupt lines count
  assign pend = mip & mie & (`MMASK_INT | `SMASK_INT);

  // MEI, MSI, MTI, SEI, SSI, STI
  always_comb begin
    if (pend[IRQ_MEI]) begin
      irq_cause = IRQ_MEI;
    end else if (pend[IRQ_MSI]) begin
      irq_cause = IRQ_MSI;
    end else if (pend[IRQ_MTI]) begin
      irq_cause = IRQ_MTI;
    end else if (pend[IRQ_SEI]) begin
      irq_cause = IRQ_SEI;
    end else if (pend[IRQ_SSI]) begin
      irq_cause = IRQ_SSI;
    end else begin
      irq_cause = IRQ_STI;
    end
  end

  // Below M the global enable does not apply
  assign irq_take = (|pend) && ((priv != PRIV_M) || mstatus[`MSTATUS_MIE]);

endmodule

//--- src/trap_ctrl.sv
`include "csr_macros.svh"

module trap_ctrl (
  input  logic                     clk,
  input  logic                     rst_n,
  input  csr_bus_pkg::trap_evt_t   evt,
  input  logic                     irq_take,
  input  csr_arch_pkg::irq_cause_t irq_cause,
  input  csr_arch_pkg::priv_t      priv,
  input  csr_arch_pkg::csr_word_t  mstatus,
  input  csr_arch_pkg::csr_word_t  medeleg,
  input  csr_arch_pkg::csr_word_t  mtvec,
  input  csr_arch_pkg::csr_word_t  stvec,
  input  csr_arch_pkg::csr_word_t  mepc,
  input  csr_arch_pkg::csr_word_t  sepc,
  output csr_bus_pkg::bank_wr_t    trap_req,
  output logic                     redirect_valid,
  output csr_arch_pkg::csr_word_t  redirect_pc
);

  import csr_arch_pkg::*;
  import csr_bus_pkg::*;

  logic      to_s;
  csr_word_t tvec_sel;
  csr_word_t tvec_base;
  csr_word_t target_pc;

  // Delegation only applies to exceptions taken below M
  assign to_s = (evt.kind == TRAP_EXC) && (priv != PRIV_M) && medeleg[evt.cause];

  assign tvec_sel  = to_s ? stvec : mtvec;
  assign tvec_base = {tvec_sel[`XLEN-1:2], 2'b00};

  always_comb begin
    trap_req     = '0;
    trap_req.epc = evt.pc;
    target_pc    = tvec_base;
    case (evt.kind)
      TRAP_EXC: begin
        trap_req.kind   = WR_ENTER;
        trap_req.addr   = to_s ? CSR_SEPC : CSR_MEPC;
        trap_req.cause  = {{(`XLEN-4){1'b0}}, evt.cause};
        trap_req.tval   = evt.tval;
        trap_req.target = to_s ? PRIV_S : PRIV_M;
      end
      TRAP_MRET: begin
        trap_req.kind   = WR_RETURN;
        trap_req.addr   = CSR_MEPC;
        trap_req.target = priv_t'(mstatus[`MSTATUS_MPP_LO +: 2]);
        target_pc       = mepc;
      end
      TRAP_SRET: begin
        trap_req.kind   = WR_RETURN;
        trap_req.addr   = CSR_SEPC;
        trap_req.target = priv_t'({1'b0, mstatus[`MSTATUS_SPP]});
        target_pc       = sepc;
      end
      default: begin
        // Interrupts only when no event is present
        if (irq_take) begin
          trap_req.kind   = WR_ENTER;
          trap_req.addr   = CSR_MEPC;
          trap_req.cause  = {1'b1, {(`XLEN-5){1'b0}}, irq_cause};
          trap_req.target = PRIV_M;
          if (mtvec[`TVEC_MODE_BIT]) begin
            target_pc = tvec_base + {{(`XLEN-6){1'b0}}, irq_cause, 2'b00};
          end
        end
      end
    endcase
    trap_req.data = target_pc;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      redirect_valid <= 1'b0;
    end else begin
      redirect_valid <= (trap_req.kind != WR_IDLE);
    end
  end

  always_ff @(posedge clk) begin
    if (trap_req.kind != WR_IDLE) begin
      redirect_pc <= target_pc;
    end
  end

  a_mret_from_m: assert property (@(posedge clk) disable iff (!rst_n)
    (evt.kind == TRAP_MRET) |-> (priv == PRIV_M));

  // Checks the bank update one edge later
  a_m_entry_masks: assert property (@(posedge clk) disable iff (!rst_n)
    (trap_req.kind == WR_ENTER) && (trap_req.target == PRIV_M)
    |=> !mstatus[`MSTATUS_MIE] && (priv == PRIV_M));

endmodule

//--- verif/csr_unit_tb.sv
`include "csr_macros.svh"

module csr_unit_tb;

  import csr_arch_pkg::*;
  import csr_bus_pkg::*;

  localparam csr_word_t SS_MASK = (32'd1 << `MSTATUS_SIE) | (32'd1 << `MSTATUS_SPIE)
                                | (32'd1 << `MSTATUS_SPP);
  localparam csr_word_t INT_MASK = `MMASK_INT | `SMASK_INT;

  // Supervisor addresses first, machine addresses from index 8
  localparam csr_addr_t ADDRS [18] = '{
    CSR_SSTATUS, CSR_SIE, CSR_STVEC, CSR_SSCRATCH, CSR_SEPC, CSR_SCAUSE, CSR_STVAL, CSR_SIP,
    CSR_MSTATUS, CSR_MISA, CSR_MEDELEG, CSR_MIE, CSR_MTVEC, CSR_MSCRATCH, CSR_MEPC,
    CSR_MCAUSE, CSR_MTVAL, CSR_MIP
  };
  localparam exc_cause_t CAUSES [10] = '{
    EXC_INSTR_MISALIGN, EXC_ILLEGAL_INSTR, EXC_BREAKPOINT, EXC_LOAD_MISALIGN, EXC_LOAD_FAULT,
    EXC_STORE_MISALIGN, EXC_STORE_FAULT, EXC_ECALL_U, EXC_ECALL_S, EXC_ECALL_M
  };
  localparam irq_cause_t IRQS [6] = '{IRQ_SSI, IRQ_MSI, IRQ_STI, IRQ_MTI, IRQ_SEI, IRQ_MEI};

  logic        clk;
  logic        rst_n;
  logic        req_valid;
  logic        req_ready;
  csr_req_t    req;
  logic        rsp_valid;
  csr_rsp_t    rsp;
  trap_evt_t   evt;
  logic        redirect_valid;
  csr_word_t   redirect_pc;
  priv_t       priv;
  logic        machine_interrupt;
  logic [15:0] lfsr = 16'd62670;

  // Reference model, raw registers indexed by CSR address
  csr_word_t   m_csr [4096];
  priv_t       m_priv;
  int          irq_count;

  csr_unit u_dut (
    .clk               (clk),
    .rst_n             (rst_n),
    .req_valid         (req_valid),
    .req_ready         (req_ready),
    .req               (req),
    .rsp_valid         (rsp_valid),
    .rsp               (rsp),
    .evt               (evt),
    .redirect_valid    (redirect_valid),
    .redirect_pc       (redirect_pc),
    .priv              (priv),
    .machine_interrupt (machine_interrupt)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Galois LFSR, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    end
    return v;
  endfunction

  function automatic csr_op_t pick_op();
    csr_word_t v;
    v = rand_bits(8) % 3;
    return csr_op_t'(v[1:0]);
  endfunction

  function automatic csr_addr_t pick_addr();
    int idx;
    idx = rand_bits(8) % 18;
    return ADDRS[idx];
  endfunction

  function automatic csr_addr_t pick_m_addr();
    int idx;
    idx = 8 + rand_bits(8) % 10;
    return ADDRS[idx];
  endfunction

  function automatic exc_cause_t pick_cause();
    int idx;
    idx = rand_bits(8) % 10;
    return CAUSES[idx];
  endfunction

  function automatic priv_t pick_priv();
    csr_word_t v;
    v = rand_bits(2);
    case (v[1:0])
      2'd0:    return PRIV_U;
      2'd1:    return PRIV_S;
      default: return PRIV_M;
    endcase
  endfunction

  // No event, but a fresh pc for a possible interrupt
  function automatic trap_evt_t quiet_evt();
    trap_evt_t e;
    e.kind  = TRAP_NONE;
    e.cause = EXC_INSTR_MISALIGN;
    e.pc    = rand_bits(32) & ~32'h3;
    e.tval  = rand_bits(32);
    return e;
  endfunction

  function automatic logic is_legal(input logic [11:0] a, input priv_t p);
    logic known;
    known = 1'b0;
    foreach (ADDRS[i]) begin
      if (ADDRS[i] == a) begin
        known = 1'b1;
      end
    end
    return known && (a[9:8] <= p);
  endfunction

  function automatic csr_word_t model_read(input logic [11:0] a);
    case (a)
      CSR_SSTATUS: return m_csr[CSR_MSTATUS] & SS_MASK;
      CSR_SIE:     return m_csr[CSR_MIE] & `SMASK_INT;
      CSR_SIP:     return m_csr[CSR_MIP] & `SMASK_INT;
      CSR_MISA:    return `MISA_RESET;
      default:     return m_csr[a];
    endcase
  endfunction

  function automatic csr_word_t new_value(input csr_req_t r, input csr_word_t old);
    case (r.op)
      CSR_RW:  return r.wdata;
      CSR_RS:  return old | r.wdata;
      default: return old & ~r.wdata;
    endcase
  endfunction

  function automatic logic [3:0] pick_irq(input csr_word_t pend);
    if (pend[IRQ_MEI]) return IRQ_MEI;
    if (pend[IRQ_MSI]) return IRQ_MSI;
    if (pend[IRQ_MTI]) return IRQ_MTI;
    if (pend[IRQ_SEI]) return IRQ_SEI;
    if (pend[IRQ_SSI]) return IRQ_SSI;
    return IRQ_STI;
  endfunction

  task automatic model_write(input logic [11:0] a, input csr_word_t d);
    case (a)
      CSR_SSTATUS: m_csr[CSR_MSTATUS] = (m_csr[CSR_MSTATUS] & ~SS_MASK) | (d & SS_MASK);
      CSR_SIE:     m_csr[CSR_MIE] = (m_csr[CSR_MIE] & ~`SMASK_INT) | (d & `SMASK_INT);
      CSR_SIP:     m_csr[CSR_MIP] = (m_csr[CSR_MIP] & ~`SMASK_INT) | (d & `SMASK_INT);
      CSR_MSTATUS: begin
        m_csr[CSR_MSTATUS] = d;
        // Reserved MPP encoding reads back as U
        if (d[`MSTATUS_MPP_LO +: 2] == 2'b10) begin
          m_csr[CSR_MSTATUS][`MSTATUS_MPP_LO +: 2] = PRIV_U;
        end
      end
      default: m_csr[a] = d;
    endcase
  endtask

  task automatic model_trap(input trap_evt_t e, input logic irq, output csr_word_t tgt);
    csr_word_t  st;
    logic       exc;
    logic       to_s;
    logic [3:0] ic;
    st  = m_csr[CSR_MSTATUS];
    exc = (e.kind == TRAP_EXC);
    ic  = pick_irq(m_csr[CSR_MIP] & m_csr[CSR_MIE] & INT_MASK);
    tgt = '0;
    if (e.kind == TRAP_MRET) begin
      tgt                      = m_csr[CSR_MEPC];
      m_priv                   = priv_t'(st[`MSTATUS_MPP_LO +: 2]);
      st[`MSTATUS_MIE]         = st[`MSTATUS_MPIE];
      st[`MSTATUS_MPIE]        = 1'b1;
      st[`MSTATUS_MPP_LO +: 2] = PRIV_U;
    end else if (e.kind == TRAP_SRET) begin
      tgt               = m_csr[CSR_SEPC];
      m_priv            = priv_t'({1'b0, st[`MSTATUS_SPP]});
      st[`MSTATUS_SIE]  = st[`MSTATUS_SPIE];
      st[`MSTATUS_SPIE] = 1'b1;
      st[`MSTATUS_SPP]  = 1'b0;
    end else if (exc || irq) begin
      to_s = exc && (m_priv != PRIV_M) && m_csr[CSR_MEDELEG][e.cause];
      if (to_s) begin
        tgt               = {m_csr[CSR_STVEC][31:2], 2'b00};
        st[`MSTATUS_SPP]  = m_priv[0];
        st[`MSTATUS_SPIE] = st[`MSTATUS_SIE];
        st[`MSTATUS_SIE]  = 1'b0;
        m_csr[CSR_SEPC]   = e.pc;
        m_csr[CSR_SCAUSE] = {28'd0, e.cause};
        m_csr[CSR_STVAL]  = e.tval;
        m_priv            = PRIV_S;
      end else begin
        tgt = {m_csr[CSR_MTVEC][31:2], 2'b00};
        // Vectored mode only moves interrupts
        if (!exc && m_csr[CSR_MTVEC][`TVEC_MODE_BIT]) begin
          tgt = tgt + (csr_word_t'(ic) << 2);
        end
        st[`MSTATUS_MPP_LO +: 2] = m_priv;
        st[`MSTATUS_MPIE]        = st[`MSTATUS_MIE];
        st[`MSTATUS_MIE]         = 1'b0;
        m_csr[CSR_MEPC]          = e.pc;
        m_csr[CSR_MCAUSE]        = exc ? {28'd0, e.cause} : {1'b1, 27'd0, ic};
        m_csr[CSR_MTVAL]         = exc ? e.tval : '0;
        m_priv                   = PRIV_M;
        if (!exc) begin
          irq_count++;
        end
      end
    end
    m_csr[CSR_MSTATUS] = st;
  endtask

  task automatic stop_with_failure();
    $display(">>> FAIL");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check_flag(input logic got, input logic want, input string what);
    if (got !== want) begin
      $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, want);
      stop_with_failure();
    end
  endtask

  task automatic check_rsp(input csr_rsp_t got, input csr_rsp_t want);
    if (got !== want) begin
      $display("[ERROR] %0t: response rdata %h illegal %b, expected rdata %h illegal %b",
               $time, got.rdata, got.illegal, want.rdata, want.illegal);
      stop_with_failure();
    end
  endtask

  task automatic check_redirect(input csr_word_t got, input csr_word_t want);
    if (got !== want) begin
      $display("[ERROR] %0t: redirect_pc is %h, expected %h", $time, got, want);
      stop_with_failure();
    end
  endtask

  task automatic check_priv(input priv_t got, input priv_t want);
    if (got !== want) begin
      $display("[ERROR] %0t: priv is %0d, expected %0d", $time, got, want);
      stop_with_failure();
    end
  endtask

  // One clock cycle: drive, predict, check the combinational and registered results
  task automatic run_cycle(input logic v, input csr_req_t r, input trap_evt_t e,
                           output logic xfer);
    logic      irq;
    logic      trap;
    csr_word_t tgt;
    csr_rsp_t  want;
    req_valid    = v;
    req          = r;
    evt          = e;
    irq          = ((m_csr[CSR_MIP] & m_csr[CSR_MIE] & INT_MASK) != '0)
                   && ((m_priv != PRIV_M) || m_csr[CSR_MSTATUS][`MSTATUS_MIE]);
    trap         = (e.kind != TRAP_NONE) || irq;
    xfer         = v && !trap;
    want.illegal = !is_legal(r.addr, m_priv);
    want.rdata   = want.illegal ? '0 : model_read(r.addr);
    tgt          = '0;
    #18;
    check_flag(req_ready, !trap, "req_ready");
    check_flag(machine_interrupt, irq, "machine_interrupt");
    if (trap) begin
      model_trap(e, irq, tgt);
    end else if (xfer && !want.illegal && (r.addr != CSR_MISA)) begin
      model_write(r.addr, new_value(r, want.rdata));
    end
    @(posedge clk);
    #1;
    check_flag(rsp_valid, xfer, "rsp_valid");
    if (xfer) begin
      check_rsp(rsp, want);
    end
    check_flag(redirect_valid, trap, "redirect_valid");
    if (trap) begin
      check_redirect(redirect_pc, tgt);
    end
    check_priv(priv, m_priv);
    #1;
  endtask

  task automatic csr_access_op(input csr_op_t op, input logic [11:0] a, input csr_word_t d);
    csr_req_t r;
    logic     done;
    int       n;
    r.op    = op;
    r.addr  = csr_addr_t'(a);
    r.wdata = d;
    done    = 1'b0;
    n       = 0;
    while (!done && (n < 16)) begin
      run_cycle(1'b1, r, quiet_evt(), done);
      n++;
    end
    if (!done) begin
      $display("Timeout: CSR request to address %h was not accepted within 16 cycles", a);
      stop_with_failure();
    end
  endtask

  task automatic send_event(input trap_kind_t k, input exc_cause_t c);
    trap_evt_t e;
    logic      x;
    e       = quiet_evt();
    e.kind  = k;
    e.cause = c;
    run_cycle(1'b0, csr_req_t'(0), e, x);
  endtask

  // Leaves machine mode through mret with MPP set to p
  task automatic enter_priv(input priv_t p);
    csr_word_t st;
    st                       = rand_bits(32);
    st[`MSTATUS_MPP_LO +: 2] = p;
    csr_access_op(CSR_RW, CSR_MIE, '0);
    csr_access_op(CSR_RW, CSR_MSTATUS, st);
    csr_access_op(CSR_RW, CSR_MEPC, rand_bits(32) & ~32'h3);
    send_event(TRAP_MRET, EXC_INSTR_MISALIGN);
  endtask

  // Breakpoints are never delegated, so this always lands in M
  task automatic return_to_m();
    if (m_priv != PRIV_M) begin
      send_event(TRAP_EXC, EXC_BREAKPOINT);
    end
  endtask

  initial begin
    irq_cause_t line;
    csr_req_t   held;
    trap_evt_t  hit;
    logic       moved;
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    evt       = '0;
    m_priv    = PRIV_M;
    irq_count = 0;
    foreach (ADDRS[i]) begin
      m_csr[ADDRS[i]] = '0;
    end
    repeat (16) @(posedge clk);
    #1;
    check_flag(rsp_valid, 1'b0, "rsp_valid in reset");
    check_flag(redirect_valid, 1'b0, "redirect_valid in reset");
    check_flag(machine_interrupt, 1'b0, "machine_interrupt in reset");
    check_priv(priv, PRIV_M);
    #1;
    rst_n = 1'b1;

    // Random CSR traffic in machine mode
    repeat (300) begin
      csr_access_op(pick_op(), pick_addr(), rand_bits(32));
    end

    // Exceptions, delegation, illegal accesses and returns
    repeat (80) begin
      return_to_m();
      csr_access_op(CSR_RW, CSR_MEDELEG, rand_bits(16) & ~(32'd1 << EXC_BREAKPOINT));
      csr_access_op(CSR_RW, CSR_STVEC, rand_bits(32));
      csr_access_op(CSR_RW, CSR_MTVEC, rand_bits(32));
      enter_priv(pick_priv());
      if (m_priv != PRIV_M) begin
        csr_access_op(pick_op(), pick_m_addr(), rand_bits(32));
      end
      // Bits 7:6 = 10 never match an implemented address
      csr_access_op(pick_op(), (rand_bits(12) & 32'hF3F) | 32'h080, rand_bits(32));
      send_event(TRAP_EXC, pick_cause());
      if (m_priv == PRIV_S) begin
        csr_access_op(CSR_RS, CSR_SEPC, '0);
        csr_access_op(CSR_RS, CSR_SCAUSE, '0);
        csr_access_op(CSR_RS, CSR_STVAL, '0);
        send_event(TRAP_SRET, EXC_INSTR_MISALIGN);
      end else begin
        csr_access_op(CSR_RS, CSR_MEPC, '0);
        csr_access_op(CSR_RS, CSR_MCAUSE, '0);
        csr_access_op(CSR_RS, CSR_MTVAL, '0);
        send_event(TRAP_MRET, EXC_INSTR_MISALIGN);
      end
    end

    // Machine interrupts, direct and vectored
    repeat (30) begin
      return_to_m();
      line = IRQS[rand_bits(8) % 6];
      csr_access_op(CSR_RC, CSR_MSTATUS, 32'd1 << `MSTATUS_MIE);
      csr_access_op(CSR_RW, CSR_MTVEC, rand_bits(32));
      csr_access_op(CSR_RW, CSR_MIE, (rand_bits(12) & INT_MASK) | (32'd1 << line));
      csr_access_op(CSR_RW, CSR_MIP, (rand_bits(12) & INT_MASK) | (32'd1 << line));
      csr_access_op(CSR_RS, CSR_MSTATUS, 32'd1 << `MSTATUS_MIE);
      send_event(TRAP_NONE, EXC_INSTR_MISALIGN);
      csr_access_op(CSR_RS, CSR_MCAUSE, '0);
      csr_access_op(CSR_RS, CSR_MSTATUS, '0);
      csr_access_op(CSR_RW, CSR_MIP, '0);
    end

    // Request held while an exception takes the write port
    repeat (20) begin
      return_to_m();
      held.op    = pick_op();
      held.addr  = pick_m_addr();
      held.wdata = rand_bits(32);
      hit        = quiet_evt();
      hit.kind   = TRAP_EXC;
      hit.cause  = pick_cause();
      run_cycle(1'b1, held, hit, moved);
      csr_access_op(held.op, held.addr, held.wdata);
    end

    send_event(TRAP_NONE, EXC_INSTR_MISALIGN);
    if (irq_count == 0) begin
      $display("No machine interrupt was taken during the run");
      stop_with_failure();
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule
